//--- flist.f
+incdir+include
src/trs_io_pkg.sv
src/spi_byte_link.sv
src/cmd_parser.sv
src/bp_slot.sv
src/bp_hit_detect.sv
src/trs_io_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_trs_io.sv

//--- Bender.yml
package:
  name: trs_io

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/trs_io_pkg.sv
      - src/spi_byte_link.sv
      - src/cmd_parser.sv
      - src/bp_slot.sv
      - src/bp_hit_detect.sv
      - src/trs_io_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_checker.sv
      - dv/tb_trs_io.sv

//--- dv/tb_trs_io.sv
`timescale 1ns/1ps
`include "trs_io_defs.svh"

module tb_trs_io
  import trs_io_pkg::*;
();

  logic                     clk;
  logic                     arst_n;
  logic                     sck;
  logic                     cs_n;
  logic                     mosi;
  logic                     miso;
  logic [`TRS_ADDR_W-1:0]   z80_addr;
  logic                     z80_rd_n;
  logic                     z80_wait;
  logic                     note_valid;  // tells the checker a command went out
  cmd_e                     note_cmd;
  logic [`TRS_BP_IDX_W-1:0] note_idx;
  logic [`TRS_ADDR_W-1:0]   note_addr;
  logic                     reply_check;
  cmd_e                     reply_cmd;
  logic                     test_end;
  int                       test_id;
  int                       checks;
  int                       errors;
  integer                   seed;

  tb_clk_gen clk_gen_inst (
    .clk    (clk),
    .arst_n (arst_n)
  );

  trs_io_top trs_io_top_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .sck      (sck),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso),
    .z80_addr (z80_addr),
    .z80_rd_n (z80_rd_n),
    .z80_wait (z80_wait)
  );

  tb_checker checker_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .miso        (miso),
    .z80_rd_n    (z80_rd_n),
    .z80_addr    (z80_addr),
    .z80_wait    (z80_wait),
    .note_valid  (note_valid),
    .note_cmd    (note_cmd),
    .note_idx    (note_idx),
    .note_addr   (note_addr),
    .reply_check (reply_check),
    .reply_cmd   (reply_cmd),
    .test_end    (test_end),
    .test_id     (test_id),
    .checks      (checks),
    .errors      (errors)
  );

  task automatic abort_run(input string why);
    $display("error: %s", why);
    $display("Test failed");
    $finish;
  endtask

  task automatic tick();
    @(posedge clk);
    #5;  // inputs change just after the edge
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) tick();
  endtask

  // mode 0 byte msb first with an sck half period of 8 clocks
  task automatic spi_byte(input byte_t b);
    for (int i = 7; i >= 0; i--) begin
      mosi = b[i];
      idle_cycles(8);
      sck = 1'b1;
      idle_cycles(8);
      sck = 1'b0;
    end
    idle_cycles(10);  // gap between bytes
  endtask

  task automatic frame_begin();
    cs_n = 1'b0;
    idle_cycles(4);
  endtask

  task automatic frame_end();
    cs_n = 1'b1;
    idle_cycles(6);
  endtask

  task automatic send_cmd(input cmd_e cmd, input logic [`TRS_BP_IDX_W-1:0] idx,
                          input logic [`TRS_ADDR_W-1:0] addr);
    frame_begin();
    spi_byte(cmd);
    if (cmd == set_breakpoint || cmd == clear_breakpoint) spi_byte(byte_t'(idx));
    if (cmd == set_breakpoint) begin
      spi_byte(addr[7:0]);   // lo first
      spi_byte(addr[15:8]);
    end
    note_cmd   = cmd;
    note_idx   = idx;
    note_addr  = addr;
    note_valid = 1'b1;
    tick();
    note_valid = 1'b0;
    frame_end();
  endtask

  // command then a dummy byte that carries the reply back
  task automatic query(input cmd_e cmd);
    frame_begin();
    spi_byte(cmd);
    reply_cmd   = cmd;
    reply_check = 1'b1;
    spi_byte(8'hff);
    reply_check = 1'b0;
    frame_end();
  endtask

  task automatic await_wait_level(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (z80_wait !== level && n < limit) begin
      tick();
      n++;
    end
    if (z80_wait !== level) abort_run(what);
  endtask

  task automatic z80_read(input logic [`TRS_ADDR_W-1:0] addr, input logic hit_expected);
    z80_addr = addr;
    z80_rd_n = 1'b0;
    if (hit_expected) await_wait_level(1'b1, 20, "z80_wait never rose on a breakpoint read");
    idle_cycles(10);
    z80_rd_n = 1'b1;
    idle_cycles(4);
  endtask

  task automatic end_test(input int id);
    test_id  = id;
    test_end = 1'b1;
    tick();
    test_end = 1'b0;
  endtask

  initial begin
    logic [`TRS_ADDR_W-1:0]   a;
    logic [`TRS_ADDR_W-1:0]   a2;
    logic [`TRS_ADDR_W-1:0]   b;
    logic [`TRS_BP_IDX_W-1:0] k;
    logic [`TRS_BP_IDX_W-1:0] lo;
    logic [`TRS_BP_IDX_W-1:0] hi;
    int                       n;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    z80_addr    = '0;
    z80_rd_n    = 1'b1;  // bus idle
    note_valid  = 1'b0;
    note_cmd    = get_cookie;
    note_idx    = '0;
    note_addr   = '0;
    reply_check = 1'b0;
    reply_cmd   = get_cookie;
    test_end    = 1'b0;
    test_id     = 0;
    seed        = 32'h242eaeb5;
    n = 0;
    while (!arst_n && n < 40) begin
      tick();
      n++;
    end
    if (!arst_n) abort_run("reset was never released");
    idle_cycles(4);

    query(get_cookie);
    end_test(1);
    query(get_version);
    end_test(2);

    // single breakpoint hit
    k = $random(seed);
    a = $random(seed);
    send_cmd(set_breakpoint, k, a);
    send_cmd(enable_breakpoints, '0, '0);
    z80_read(a, 1'b1);
    query(get_bp_status);
    end_test(3);

    // after resume a cleared slot and a disabled unit stay quiet
    send_cmd(xray_resume, '0, '0);
    await_wait_level(1'b0, 20, "z80_wait did not drop after xray_resume");
    query(get_bp_status);
    send_cmd(clear_breakpoint, k, '0);
    z80_read(a, 1'b0);
    send_cmd(set_breakpoint, k, a);
    send_cmd(disable_breakpoints, '0, '0);
    z80_read(a, 1'b0);
    query(get_bp_status);
    end_test(4);

    // two slots on one address report the lower index
    a2 = $random(seed);
    if (a2 == a) a2 = a + 1'b1;
    lo = k;
    hi = k ^ 3'd5;
    if (hi < lo) begin
      lo = hi;
      hi = k;
    end
    send_cmd(enable_breakpoints, '0, '0);
    send_cmd(set_breakpoint, hi, a2);
    send_cmd(set_breakpoint, lo, a2);
    z80_read(a2, 1'b1);
    query(get_bp_status);
    send_cmd(xray_resume, '0, '0);
    await_wait_level(1'b0, 20, "z80_wait did not drop after xray_resume");
    end_test(5);

    // random reads away from the armed addresses
    for (int i = 0; i < 12; i++) begin
      b = $random(seed);
      while (b == a || b == a2) b = b + 1'b1;
      z80_read(b, 1'b0);
    end
    query(get_bp_status);
    end_test(6);

    idle_cycles(4);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- dv/tb_checker.sv
`timescale 1ns/1ps
`include "trs_io_defs.svh"

module tb_checker
  import trs_io_pkg::*;
(
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     sck,
  input  logic                     miso,
  input  logic                     z80_rd_n,
  input  logic [`TRS_ADDR_W-1:0]   z80_addr,
  input  logic                     z80_wait,
  input  logic                     note_valid,   // host finished a command
  input  cmd_e                     note_cmd,
  input  logic [`TRS_BP_IDX_W-1:0] note_idx,
  input  logic [`TRS_ADDR_W-1:0]   note_addr,
  input  logic                     reply_check,  // high over the dummy byte
  input  cmd_e                     reply_cmd,
  input  logic                     test_end,
  input  int                       test_id,
  output int                       checks,
  output int                       errors
);

  // model of slots, enable and latched hit
  logic [`TRS_ADDR_W-1:0]   m_addr [`TRS_NUM_BP];
  logic [`TRS_NUM_BP-1:0]   m_armed;
  logic                     m_en;
  logic                     m_hit;
  logic [`TRS_BP_IDX_W-1:0] m_idx;
  logic                     rd_q;      // previous rd_n sample
  logic                     sck_q;
  byte_t                    rx;        // miso bits of the reply
  int                       nbits;
  int                       err_mark;  // errors at start of current test

  initial begin
    m_armed  = '0;
    m_en     = 1'b0;
    m_hit    = 1'b0;
    m_idx    = '0;
    rd_q     = 1'b1;
    sck_q    = 1'b0;
    rx       = '0;
    nbits    = 0;
    checks   = 0;
    errors   = 0;
    err_mark = 0;
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH time %0t: %s", $time, msg);
    errors++;
  endtask

  // new hit on a read where the lowest armed slot wins
  function automatic logic [`TRS_BP_IDX_W:0] ref_read_hit(input logic [`TRS_ADDR_W-1:0] a);
    logic [`TRS_BP_IDX_W:0] r;
    r = '0;
    if (m_en && !m_hit) begin  // held hit blocks new ones
      for (int i = `TRS_NUM_BP - 1; i >= 0; i--) begin
        if (m_armed[i] && (m_addr[i] == a)) r = {1'b1, i[`TRS_BP_IDX_W-1:0]};
      end
    end
    return r;
  endfunction

  function automatic byte_t expected_reply(input cmd_e cmd);
    case (cmd)
      get_cookie:    return `TRS_COOKIE;
      get_version:   return (byte_t'(`TRS_VER_MAJOR) << 5) | byte_t'(`TRS_VER_MINOR);
      get_bp_status: return {m_hit, 4'b0000, m_idx};  // hit, zeros, index
      default:       return 8'h00;
    endcase
  endfunction

  task automatic apply_note();
    int n;
    n = 0;
    case (note_cmd)
      set_breakpoint: begin
        m_addr[note_idx]  = note_addr;
        m_armed[note_idx] = 1'b1;
      end
      clear_breakpoint:    m_armed[note_idx] = 1'b0;
      enable_breakpoints:  m_en = 1'b1;
      disable_breakpoints: m_en = 1'b0;
      xray_resume: begin
        m_hit = 1'b0;
        m_idx = '0;
        checks++;
        while (z80_wait && n < 8) begin
          @(posedge clk);
          n++;
        end
        if (z80_wait) report_mismatch("z80_wait still high after xray_resume");
      end
      default: ;
    endcase
  endtask

  task automatic check_read();
    logic [`TRS_BP_IDX_W:0] r;
    int n;
    r = ref_read_hit(z80_addr);
    n = 0;
    if (r[`TRS_BP_IDX_W]) begin
      m_hit = 1'b1;
      m_idx = r[`TRS_BP_IDX_W-1:0];
    end
    checks++;
    if (m_hit) begin
      while (!z80_wait && n < 4) begin  // wait bound from rd_n fall
        @(posedge clk);
        n++;
      end
      if (!z80_wait)
        report_mismatch($sformatf("z80_wait low 4 cycles after read of %h", z80_addr));
    end else begin
      while (!z80_wait && n < 6) begin
        @(posedge clk);
        n++;
      end
      if (z80_wait) report_mismatch($sformatf("z80_wait raised on read of %h", z80_addr));
    end
  endtask

  // commands and z80 reads
  always @(posedge clk) begin
    if (arst_n) begin
      if (note_valid) begin
        apply_note();
      end else if (rd_q && !z80_rd_n) begin
        check_read();
      end
    end
    rd_q = z80_rd_n;
  end

  // reply bytes with miso taken at each sck rise of the dummy byte
  always @(posedge clk) begin
    if (!reply_check) begin
      nbits = 0;
    end else if (sck && !sck_q) begin
      rx = {rx[6:0], miso};
      nbits++;
      if (nbits == 8) begin
        checks++;
        if (rx !== expected_reply(reply_cmd))
          report_mismatch($sformatf("reply to cmd %0d is %h, expected %h",
                                    reply_cmd, rx, expected_reply(reply_cmd)));
        nbits = 0;
      end
    end
    sck_q = sck;
  end

  always @(posedge clk) begin
    if (test_end) begin
      if (errors == err_mark) $display("test %0d ok", test_id);
      else $display("test %0d bad, %0d errors", test_id, errors - err_mark);
      err_mark = errors;
    end
  end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // reset held for 16 cycles and released off the edge
  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge clk);
    #5 arst_n = 1'b1;
  end

endmodule

//--- src/trs_io_top.sv
`timescale 1ns/1ps
`include "trs_io_defs.svh"

module trs_io_top
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  mosi,
  output logic  miso,
  input  addr_t z80_addr,
  input  logic  z80_rd_n,
  output logic  z80_wait
);

  logic                   rx_valid;
  byte_t                  rx_byte;
  logic                   frame_start;
  logic                   tx_load;
  byte_t                  tx_byte;
  logic                   bp_set;
  logic                   bp_clear;
  bp_idx_t                bp_sel_idx;
  addr_t                  bp_addr;
  logic                   bp_enable_stb;
  logic                   bp_enable;
  logic                   bp_resume;
  bp_status_t             bp_status;
  logic [`TRS_NUM_BP-1:0] match;  // one per slot

  // esp side spi
  spi_byte_link spi_byte_link_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .rx_valid    (rx_valid),
    .rx_byte     (rx_byte),
    .frame_start (frame_start),
    .tx_load     (tx_load),
    .tx_byte     (tx_byte)
  );

  cmd_parser cmd_parser_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .rx_valid      (rx_valid),
    .rx_byte       (rx_byte),
    .frame_start   (frame_start),
    .tx_load       (tx_load),
    .tx_byte       (tx_byte),
    .bp_set        (bp_set),
    .bp_clear      (bp_clear),
    .bp_sel_idx    (bp_sel_idx),
    .bp_addr       (bp_addr),
    .bp_enable_stb (bp_enable_stb),
    .bp_enable     (bp_enable),
    .bp_resume     (bp_resume),
    .bp_status     (bp_status)
  );

  for (genvar g = 0; g < `TRS_NUM_BP; g++) begin : gen_slot
    bp_slot #(.SLOT_ID(g)) bp_slot_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .bp_set     (bp_set),
      .bp_clear   (bp_clear),
      .bp_sel_idx (bp_sel_idx),
      .bp_addr    (bp_addr),
      .z80_addr   (z80_addr),
      .match      (match[g])
    );
  end

  // z80 side raises wait on an armed read
  bp_hit_detect bp_hit_detect_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .rd_n          (z80_rd_n),
    .match         (match),
    .bp_enable_stb (bp_enable_stb),
    .bp_enable     (bp_enable),
    .bp_resume     (bp_resume),
    .bp_status     (bp_status),
    .z80_wait      (z80_wait)
  );

endmodule

//--- src/bp_hit_detect.sv
`timescale 1ns/1ps
`include "trs_io_defs.svh"

module bp_hit_detect
  import trs_io_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   rd_n,
  input  logic [`TRS_NUM_BP-1:0] match,
  input  logic                   bp_enable_stb,
  input  logic                   bp_enable,
  input  logic                   bp_resume,
  output bp_status_t             bp_status,
  output logic                   z80_wait
);

  localparam int SYNC = `TRS_SYNC_STAGES;

  logic [SYNC:0] rd_sr;      // top bit holds the previous sample
  logic          rd_fall;
  logic          enabled;
  logic          hit_q;
  bp_idx_t       idx_q;
  bp_idx_t       low_idx;    // lowest matching slot

  assign rd_fall = (rd_sr[SYNC:SYNC-1] == 2'b10);

  // priority encode where the lower slot wins
  always_comb begin
    low_idx = '0;
    for (int i = `TRS_NUM_BP - 1; i >= 0; i--) begin
      if (match[i]) low_idx = bp_idx_t'(i);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_sr    <= '1;  // bus idle
      enabled  <= 1'b0;
      hit_q    <= 1'b0;
      idx_q    <= '0;
      z80_wait <= 1'b0;
    end else begin
      rd_sr    <= {rd_sr[SYNC-1:0], rd_n};
      z80_wait <= hit_q;  // one flop behind the hit
      if (bp_enable_stb) enabled <= bp_enable;
      if (bp_resume) begin
        hit_q <= 1'b0;
        idx_q <= '0;
      end else if (rd_fall && enabled && !hit_q && (|match)) begin
        hit_q <= 1'b1;  // first hit held until resume
        idx_q <= low_idx;
      end
    end
  end

  assign bp_status = '{hit: hit_q, rsvd: 4'b0, idx: idx_q};

endmodule

//--- src/bp_slot.sv
`timescale 1ns/1ps

module bp_slot
  import trs_io_pkg::*;
#(
  parameter int SLOT_ID = 0
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    bp_set,
  input  logic    bp_clear,
  input  bp_idx_t bp_sel_idx,
  input  addr_t   bp_addr,
  input  addr_t   z80_addr,
  output logic    match
);

  logic  sel;
  logic  armed;
  addr_t addr_q;

  assign sel = (bp_sel_idx == bp_idx_t'(SLOT_ID));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      armed <= 1'b0;
    end else if (sel && bp_set) begin
      armed <= 1'b1;
    end else if (sel && bp_clear) begin
      armed <= 1'b0;  // address kept and only the flag drops
    end
  end

  always_ff @(posedge clk) begin
    if (sel && bp_set) addr_q <= bp_addr;
  end

  assign match = armed && (z80_addr == addr_q);

endmodule

//--- src/cmd_parser.sv
`timescale 1ns/1ps
`include "trs_io_defs.svh"

module cmd_parser
  import trs_io_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       rx_valid,
  input  byte_t      rx_byte,
  input  logic       frame_start,
  output logic       tx_load,
  output byte_t      tx_byte,
  output logic       bp_set,
  output logic       bp_clear,
  output bp_idx_t    bp_sel_idx,
  output addr_t      bp_addr,
  output logic       bp_enable_stb,
  output logic       bp_enable,
  output logic       bp_resume,
  input  bp_status_t bp_status
);

  parse_state_e state;
  cmd_e         cmd_q;       // command owning the parameter bytes
  cmd_e         rx_cmd;
  logic [1:0]   param_cnt;   // parameter byte position
  logic         last_param;

  assign rx_cmd = cmd_e'(rx_byte);

  // set takes 3 bytes, clear only 1
  assign last_param = (cmd_q == set_breakpoint) ? (param_cnt == 2'd2) : 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= st_idle;
      cmd_q         <= get_cookie;
      param_cnt     <= '0;
      tx_load       <= 1'b0;
      bp_set        <= 1'b0;
      bp_clear      <= 1'b0;
      bp_enable_stb <= 1'b0;
      bp_enable     <= 1'b0;
      bp_resume     <= 1'b0;
    end else begin
      // one cycle strobes
      tx_load       <= 1'b0;
      bp_set        <= 1'b0;
      bp_clear      <= 1'b0;
      bp_enable_stb <= 1'b0;
      bp_resume     <= 1'b0;
      if (frame_start) begin
        state <= st_idle;  // new cs_n frame drops a half-parsed command
      end else if (rx_valid) begin
        case (state)
          st_idle: begin
            cmd_q     <= rx_cmd;
            param_cnt <= '0;
            case (rx_cmd)
              get_cookie, get_version, get_bp_status: tx_load <= 1'b1;
              enable_breakpoints: begin
                bp_enable_stb <= 1'b1;
                bp_enable     <= 1'b1;
              end
              disable_breakpoints: begin
                bp_enable_stb <= 1'b1;
                bp_enable     <= 1'b0;
              end
              xray_resume: bp_resume <= 1'b1;
              set_breakpoint, clear_breakpoint: state <= st_params;
              default: ;  // dummy 8'hff and unknown codes
            endcase
          end
          st_params: begin
            param_cnt <= param_cnt + 2'd1;
            if (last_param) begin
              state    <= st_idle;
              bp_set   <= (cmd_q == set_breakpoint);
              bp_clear <= (cmd_q == clear_breakpoint);
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  // reply byte and breakpoint parameters
  always_ff @(posedge clk) begin
    if (rx_valid && (state == st_idle)) begin
      case (rx_cmd)
        get_cookie:    tx_byte <= `TRS_COOKIE;
        get_version:   tx_byte <= {`TRS_VER_MAJOR, `TRS_VER_MINOR};
        get_bp_status: tx_byte <= bp_status;  // snapshot at command time
        default: ;
      endcase
    end
    if (rx_valid && (state == st_params)) begin
      case (param_cnt)
        2'd0:    bp_sel_idx <= rx_byte[`TRS_BP_IDX_W-1:0];
        2'd1:    bp_addr[7:0] <= rx_byte;               // addr lo
        default: bp_addr[`TRS_ADDR_W-1:8] <= rx_byte;   // addr hi arrives with bp_set
      endcase
    end
  end

endmodule

//--- src/spi_byte_link.sv
`timescale 1ns/1ps
`include "trs_io_defs.svh"

module spi_byte_link
  import trs_io_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  mosi,
  output logic  miso,
  output logic  rx_valid,
  output byte_t rx_byte,
  output logic  frame_start,
  input  logic  tx_load,
  input  byte_t tx_byte
);

  localparam int SYNC = `TRS_SYNC_STAGES;

  logic [SYNC:0]   sck_sr;   // top bit holds the previous value for edges
  logic [SYNC:0]   cs_sr;
  logic [SYNC-1:0] mosi_sr;  // same depth as sck so data lines up
  logic            sck_rise;
  logic            sck_fall;
  logic            cs_fall;
  logic            cs_active;
  logic [2:0]      bit_cnt;
  byte_t           rx_sr;
  byte_t           tx_sr;

  assign sck_rise  = (sck_sr[SYNC:SYNC-1] == 2'b01);
  assign sck_fall  = (sck_sr[SYNC:SYNC-1] == 2'b10);
  assign cs_fall   = (cs_sr[SYNC:SYNC-1] == 2'b10);
  assign cs_active = ~cs_sr[SYNC-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_sr  <= '0;
      cs_sr   <= '1;  // deselected
      mosi_sr <= '0;
    end else begin
      sck_sr  <= {sck_sr[SYNC-1:0], sck};
      cs_sr   <= {cs_sr[SYNC-1:0], cs_n};
      mosi_sr <= {mosi_sr[SYNC-2:0], mosi};
    end
  end

  // mode 0 receive samples mosi on the sck rise msb first
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt     <= '0;
      rx_sr       <= '0;
      rx_valid    <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      rx_valid    <= cs_active && sck_rise && (bit_cnt == 3'd7);
      frame_start <= cs_fall;
      if (!cs_active) begin
        bit_cnt <= '0;  // realign on every frame
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        rx_sr   <= {rx_sr[6:0], mosi_sr[SYNC-1]};
      end
    end
  end

  assign rx_byte = rx_sr;  // complete while rx_valid is high

  // transmit side
  // msb sits on miso before the first rise, then 7 falls shift the rest out
  // the trailing fall of a byte (count wrapped to 0) is skipped, so a byte
  // loaded during the current byte survives until the next one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_sr <= '0;
    end else if (tx_load) begin
      tx_sr <= tx_byte;
    end else if (cs_active && sck_fall && (bit_cnt != 3'd0)) begin
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

  assign miso = cs_active ? tx_sr[7] : 1'b0;  // no tristate here

endmodule

//--- src/trs_io_pkg.sv
`include "trs_io_defs.svh"

package trs_io_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [`TRS_ADDR_W-1:0] addr_t;
  typedef logic [`TRS_BP_IDX_W-1:0] bp_idx_t;

  // esp command codes sent as the first byte of every message
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    set_breakpoint      = 8'd6,   // idx, addr lo, addr hi
    clear_breakpoint    = 8'd7,   // idx
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    xray_resume         = 8'd13,
    get_version         = 8'd15,
    get_bp_status       = 8'd21
  } cmd_e;

  typedef enum logic [1:0] {
    st_idle,
    st_params
  } parse_state_e;

  // reply byte of get_bp_status
  typedef struct packed {
    logic       hit;
    logic [3:0] rsvd;  // always zero
    bp_idx_t    idx;
  } bp_status_t;

endpackage

//--- include/trs_io_defs.svh
`ifndef TRS_IO_DEFS_SVH
`define TRS_IO_DEFS_SVH

// reply to get_cookie so the esp can tell the fpga is alive
`define TRS_COOKIE 8'haf

// version byte is {major, minor}
`define TRS_VER_MAJOR 3'd0
`define TRS_VER_MINOR 5'd3

// z80 address bus
`define TRS_ADDR_W 16

// slot count and index width must agree
`define TRS_NUM_BP 8
`define TRS_BP_IDX_W 3

// flops per async input synchroniser
`define TRS_SYNC_STAGES 2

`endif
